// ==== all.f ====
logic/ccipPkg.sv
logic/snifferPkg.sv
logic/ruleChecker.sv
logic/hazardTracker.sv
logic/snifferRegs.sv
logic/ccipSnifferTop.sv
tb/snifferCheck.sv
tb/snifferTb.sv

// ==== logic/ccipPkg.sv ====
// Types of the observed cache-line request interface
// Request length and response type enums
// Request and response headers, per-channel beat structs
`default_nettype none

package ccipPkg;

   // Lines per request, encoded as lines minus one
   typedef enum logic [1:0] {
      cl1 = 2'd0,
      cl2 = 2'd1,
      cl3 = 2'd2,
      cl4 = 2'd3
   } clNumE;

   // Kind of response on the receive channels
   typedef enum logic {
      rdResp = 1'b0,
      wrResp = 1'b1
   } respTypeE;

   // Request header, reads on C0Tx and write beats on C1Tx
   typedef struct packed {
      // First cache line of the request
      logic [15:0] lineAddr;
      clNumE       clNum;
      // Set on the first beat of a write burst
      logic        sop;
      // Request tag, echoed back in the response
      logic [7:0]  mdata;
   } txHdrT;

   // Response header
   typedef struct packed {
      respTypeE   respType;
      logic [7:0] mdata;
   } rxHdrT;

   // One beat on C0Tx or C1Tx
   typedef struct packed {
      logic  valid;
      txHdrT hdr;
   } txChanT;

   // One beat on C0Rx or C1Rx
   typedef struct packed {
      logic  valid;
      rxHdrT hdr;
   } rxChanT;

endpackage

`default_nettype wire

// ==== logic/ccipSnifferTop.sv ====
// Cache-line interface sniffer top level
// Rule checker, in-flight tracker and APB register block
`timescale 1ns/1ps
`default_nettype none

module ccipSnifferTop #(
   parameter int trackDepth = 8
) (
   input  logic            clk,
   input  logic            rstN,
   input  logic            softReset,
   input  ccipPkg::txChanT c0Tx,
   input  ccipPkg::txChanT c1Tx,
   input  ccipPkg::rxChanT c0Rx,
   input  ccipPkg::rxChanT c1Rx,
   input  logic [7:0]      paddr,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  logic [31:0]     pwdata,
   output logic [31:0]     prdata,
   output logic            pready,
   output logic            pslverr
);
   import snifferPkg::*;

   // Accepted request, checker to tracker
   trackReqT  trackReq;
   // Violation pulses into the counters
   violPulseT chkViol;
   violPulseT trkViol;

   ruleChecker chk_i (
      .clk       (clk),
      .rstN      (rstN),
      .softReset (softReset),
      .c0Tx      (c0Tx),
      .c1Tx      (c1Tx),
      .c0Rx      (c0Rx),
      .c1Rx      (c1Rx),
      .trackReq  (trackReq),
      .chkViol   (chkViol)
   );

   // Tracker sees softReset to drop responses in that window
   hazardTracker #(
      .trackDepth (trackDepth)
   ) trk_i (
      .clk       (clk),
      .rstN      (rstN),
      .softReset (softReset),
      .trackReq  (trackReq),
      .c0Rx      (c0Rx),
      .c1Rx      (c1Rx),
      .trkViol   (trkViol)
   );

   snifferRegs regs_i (
      .clk     (clk),
      .rstN    (rstN),
      .chkViol (chkViol),
      .trkViol (trkViol),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

endmodule

`default_nettype wire

// ==== logic/hazardTracker.sv ====
// In-flight request table
// Line overlap hazard check and allocation of tracked requests
// Response tag lookup, entry free and orphan detection
`timescale 1ns/1ps
`default_nettype none

module hazardTracker #(
   parameter int trackDepth = 8
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  softReset,
   input  snifferPkg::trackReqT  trackReq,
   input  ccipPkg::rxChanT       c0Rx,
   input  ccipPkg::rxChanT       c1Rx,
   output snifferPkg::violPulseT trkViol
);
   import ccipPkg::*;
   import snifferPkg::*;

   localparam int idxW = $clog2(trackDepth);

   trackReqT tableQ [trackDepth];
   // Responses delayed one cycle to line up with trackReq
   rxChanT   c0RxQ;
   rxChanT   c1RxQ;

   logic [trackDepth-1:0] validVec;
   logic [trackDepth-1:0] c0Hit;
   logic [trackDepth-1:0] c1Hit;
   logic [trackDepth-1:0] freeMask;
   logic [trackDepth-1:0] overlapVec;
   logic                  full;
   logic                  allocEn;
   logic [idxW-1:0]       allocIdx;
   logic                  hazard;
   logic                  orphan0;
   logic                  orphan1;
   logic                  dupTag;

   // Last line covered by a request in a wider word that never wraps
   function automatic logic [16:0] lastLine(trackReqT r);
      return {1'b0, r.lineAddr} + {15'b0, r.clNum};
   endfunction

   // Compare against the table as it stood before this cycle's updates
   always_comb begin
      for (int i = 0; i < trackDepth; i++) begin
         validVec[i]   = tableQ[i].valid;
         c0Hit[i]      = tableQ[i].valid && (tableQ[i].mdata == c0RxQ.hdr.mdata);
         c1Hit[i]      = tableQ[i].valid && (tableQ[i].mdata == c1RxQ.hdr.mdata);
         // Ranges overlap when each starts before the other ends
         overlapVec[i] = tableQ[i].valid
                         && ({1'b0, trackReq.lineAddr} <= lastLine(tableQ[i]))
                         && ({1'b0, tableQ[i].lineAddr} <= lastLine(trackReq));
      end
   end

   assign freeMask = ({trackDepth{c0RxQ.valid}} & c0Hit) | ({trackDepth{c1RxQ.valid}} & c1Hit);
   assign orphan0  = c0RxQ.valid & ~(|c0Hit);
   assign orphan1  = c1RxQ.valid & ~(|c1Hit);

   // A request into a full table is neither tracked nor checked
   assign full    = &validVec;
   assign allocEn = trackReq.valid & ~full;
   assign hazard  = allocEn & (|overlapVec);

   always_comb begin
      allocIdx = '0;
      // Downward scan leaves the lowest free entry
      for (int i = trackDepth - 1; i >= 0; i--) begin
         if (!validVec[i]) begin
            allocIdx = idxW'(i);
         end
      end
   end

   // Tag priority is hazard, then C0Rx orphan, then C1Rx orphan
   always_comb begin
      trkViol        = '0;
      trkViol.hazard = hazard;
      trkViol.orphan = orphan0 | orphan1;
      if (hazard) begin
         trkViol.mdata = trackReq.mdata;
      end else if (orphan0) begin
         trkViol.mdata = c0RxQ.hdr.mdata;
      end else if (orphan1) begin
         trkViol.mdata = c1RxQ.hdr.mdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         c0RxQ.valid <= 1'b0;
         c1RxQ.valid <= 1'b0;
         for (int i = 0; i < trackDepth; i++) begin
            tableQ[i].valid <= 1'b0;
         end
      end else begin
         // Responses during soft reset never reach the table
         c0RxQ.valid <= c0Rx.valid & ~softReset;
         c1RxQ.valid <= c1Rx.valid & ~softReset;
         // Matched entries freed, new request written into a free entry
         for (int i = 0; i < trackDepth; i++) begin
            if (freeMask[i]) begin
               tableQ[i].valid <= 1'b0;
            end
            if (allocEn && allocIdx == idxW'(i)) begin
               tableQ[i] <= trackReq;
            end
         end
      end
      c0RxQ.hdr <= c0Rx.hdr;
      c1RxQ.hdr <= c1Rx.hdr;
   end

   // Pairwise tag compare over the valid entries
   always_comb begin
      dupTag = 1'b0;
      for (int i = 0; i < trackDepth; i++) begin
         for (int j = i + 1; j < trackDepth; j++) begin
            if (validVec[i] && validVec[j] && tableQ[i].mdata == tableQ[j].mdata) begin
               dupTag = 1'b1;
            end
         end
      end
   end

   // No two in-flight requests share a tag
   uniqueTag: assert property (@(posedge clk) disable iff (!rstN) !dupTag);

   // Every allocation lands on an entry that was free
   allocRoom: assert property (@(posedge clk) disable iff (!rstN)
      allocEn |-> !validVec[allocIdx]);

endmodule

`default_nettype wire

// ==== logic/ruleChecker.sv ====
// Per-beat protocol rules
// Traffic during soft reset, 3-line reads, write SOP sequencing
// Registered violation pulses and accepted requests for the tracker
`timescale 1ns/1ps
`default_nettype none

module ruleChecker (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  softReset,
   input  ccipPkg::txChanT       c0Tx,
   input  ccipPkg::txChanT       c1Tx,
   input  ccipPkg::rxChanT       c0Rx,
   input  ccipPkg::rxChanT       c1Rx,
   output snifferPkg::trackReqT  trackReq,
   output snifferPkg::violPulseT chkViol
);
   import ccipPkg::*;
   import snifferPkg::*;

   // Write burst tracking
   typedef enum logic {
      idleS,
      burstS
   } burstStateE;

   burstStateE stateQ;
   // Beats still expected in the current burst
   logic [1:0] beatsLeftQ;
   // Write start waiting behind a read from the same cycle
   trackReqT   holdQ;

   logic       rstHit;
   logic [7:0] rstTag;
   logic       rdBeat;
   logic       lenHit;
   logic       wrBeat;
   logic       sopHit;
   logic       wrStart;
   logic       holdDrain;
   logic       holdLoad;
   trackReqT   rdReq;
   trackReqT   wrReq;

   // Any channel active during soft reset, one violation per cycle
   assign rstHit = softReset & (c0Tx.valid | c1Tx.valid | c0Rx.valid | c1Rx.valid);
   // Reported tag comes from the first active channel
   assign rstTag = c0Tx.valid ? c0Tx.hdr.mdata :
                   c1Tx.valid ? c1Tx.hdr.mdata :
                   c0Rx.valid ? c0Rx.hdr.mdata : c1Rx.hdr.mdata;

   // Reads, 3-line requests are flagged and never tracked
   assign rdBeat = c0Tx.valid & ~softReset;
   assign lenHit = rdBeat & (c0Tx.hdr.clNum == cl3);
   assign rdReq  = '{valid:    rdBeat & ~lenHit,
                     lineAddr: c0Tx.hdr.lineAddr,
                     clNum:    c0Tx.hdr.clNum,
                     mdata:    c0Tx.hdr.mdata};

   // Writes, sop required outside a burst and forbidden inside
   assign wrBeat  = c1Tx.valid & ~softReset;
   assign sopHit  = wrBeat & ((stateQ == idleS) ? ~c1Tx.hdr.sop : c1Tx.hdr.sop);
   // Every sop beat opens a burst, also one that aborts an older burst
   assign wrStart = wrBeat & c1Tx.hdr.sop;
   assign wrReq   = '{valid:    wrStart,
                      lineAddr: c1Tx.hdr.lineAddr,
                      clNum:    c1Tx.hdr.clNum,
                      mdata:    c1Tx.hdr.mdata};

   // Read goes out first, hold drains on a cycle without a read
   assign holdDrain = holdQ.valid & ~rdReq.valid;
   // Write parks in hold when a read takes the slot or hold drains now
   // A write behind a full hold and a read is left untracked
   assign holdLoad  = wrStart & (rdReq.valid ? ~holdQ.valid : holdQ.valid);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         stateQ      <= idleS;
         beatsLeftQ  <= 2'd0;
         holdQ.valid <= 1'b0;
         trackReq    <= '0;
         chkViol     <= '0;
      end else begin
         // Burst FSM
         if (wrStart) begin
            stateQ     <= (c1Tx.hdr.clNum == cl1) ? idleS : burstS;
            beatsLeftQ <= c1Tx.hdr.clNum;
         end else if (wrBeat && stateQ == burstS) begin
            beatsLeftQ <= beatsLeftQ - 2'd1;
            if (beatsLeftQ == 2'd1) begin
               stateQ <= idleS;
            end
         end

         // Hold register
         if (holdLoad) begin
            holdQ <= wrReq;
         end else if (holdDrain) begin
            holdQ.valid <= 1'b0;
         end

         // One request per cycle to the tracker
         if (rdReq.valid) begin
            trackReq <= rdReq;
         end else if (holdQ.valid) begin
            trackReq <= holdQ;
         end else begin
            trackReq <= wrReq;
         end

         // Violation pulses, tag of the lowest code
         chkViol              <= '0;
         chkViol.resetTraffic <= rstHit;
         chkViol.illegalLen   <= lenHit;
         chkViol.sop          <= sopHit;
         if (rstHit) begin
            chkViol.mdata <= rstTag;
         end else if (lenHit) begin
            chkViol.mdata <= c0Tx.hdr.mdata;
         end else if (sopHit) begin
            chkViol.mdata <= c1Tx.hdr.mdata;
         end
      end
   end

   // A parked write stays intact until it has gone out on trackReq
   holdKept: assert property (@(posedge clk) disable iff (!rstN)
      holdQ.valid && !holdDrain |=> holdQ == $past(holdQ));

endmodule

`default_nettype wire

// ==== logic/snifferPkg.sv ====
// Sniffer types and constants
// Violation codes, counter width and APB register offsets
// Violation pulse and record structs, tracked request struct
`default_nettype none

package snifferPkg;

   // Violation codes, the lower code wins when several hit together
   typedef enum logic [2:0] {
      violNone         = 3'd0,
      violResetTraffic = 3'd1,
      violIllegalLen   = 3'd2,
      violSop          = 3'd3,
      violHazard       = 3'd4,
      violOrphan       = 3'd5
   } violE;

   // Saturating counter width
   localparam int cntW = 16;

   // APB register offsets
   localparam logic [7:0] regResetTraffic = 8'h00;
   localparam logic [7:0] regIllegalLen   = 8'h04;
   localparam logic [7:0] regSop          = 8'h08;
   localparam logic [7:0] regHazard       = 8'h0C;
   localparam logic [7:0] regOrphan       = 8'h10;
   localparam logic [7:0] regFirstViol    = 8'h14;
   // Bit 0 written as one clears counters and record
   localparam logic [7:0] regControl      = 8'h18;

   // First violation, reads back as valid in bit 11, code in 10:8, mdata in 7:0
   typedef struct packed {
      logic       valid;
      violE       code;
      logic [7:0] mdata;
   } violRecT;

   // One cycle of violation pulses from one source
   // mdata belongs to the lowest code that is set
   typedef struct packed {
      logic       resetTraffic;
      logic       illegalLen;
      logic       sop;
      logic       hazard;
      logic       orphan;
      logic [7:0] mdata;
   } violPulseT;

   // Accepted request from the rule checker, also one tracker table entry
   typedef struct packed {
      logic           valid;
      logic [15:0]    lineAddr;
      ccipPkg::clNumE clNum;
      logic [7:0]     mdata;
   } trackReqT;

endpackage

`default_nettype wire

// ==== logic/snifferRegs.sv ====
// APB register block
// Five saturating violation counters and the first-violation record
// Read decode, clear control and slave error on unmapped offsets
`timescale 1ns/1ps
`default_nettype none

module snifferRegs (
   input  logic                  clk,
   input  logic                  rstN,
   input  snifferPkg::violPulseT chkViol,
   input  snifferPkg::violPulseT trkViol,
   input  logic [7:0]            paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr
);
   import snifferPkg::*;

   // Counters in register order, index 0 at offset 0x00
   logic [cntW-1:0] cntQ [5];
   violRecT         firstRecQ;
   logic [4:0]      incVec;
   violRecT         chkRec;
   violRecT         trkRec;
   logic            clearAll;
   logic            addrHit;
   logic [31:0]     rdData;

   // Lowest code set in one pulse word
   function automatic violRecT pickViol(violPulseT p);
      violRecT r;
      r.valid = 1'b1;
      r.mdata = p.mdata;
      if (p.resetTraffic) begin
         r.code = violResetTraffic;
      end else if (p.illegalLen) begin
         r.code = violIllegalLen;
      end else if (p.sop) begin
         r.code = violSop;
      end else if (p.hazard) begin
         r.code = violHazard;
      end else if (p.orphan) begin
         r.code = violOrphan;
      end else begin
         r.valid = 1'b0;
         r.code  = violNone;
      end
      return r;
   endfunction

   assign incVec = {chkViol.orphan | trkViol.orphan,
                    chkViol.hazard | trkViol.hazard,
                    chkViol.sop | trkViol.sop,
                    chkViol.illegalLen | trkViol.illegalLen,
                    chkViol.resetTraffic | trkViol.resetTraffic};
   assign chkRec = pickViol(chkViol);
   assign trkRec = pickViol(trkViol);

   // Write in the access phase, only the control register reacts
   assign clearAll = psel & penable & pwrite & (paddr == regControl) & pwdata[0];

   always_comb begin
      addrHit = 1'b1;
      rdData  = 32'h0;
      case (paddr)
         regResetTraffic: rdData = 32'(cntQ[0]);
         regIllegalLen:   rdData = 32'(cntQ[1]);
         regSop:          rdData = 32'(cntQ[2]);
         regHazard:       rdData = 32'(cntQ[3]);
         regOrphan:       rdData = 32'(cntQ[4]);
         regFirstViol:    rdData = 32'(firstRecQ);
         // Clear bit is self-clearing, reads as zero
         regControl:      rdData = 32'h0;
         default:         addrHit = 1'b0;
      endcase
   end

   // Clear wins over increments in the same cycle
   always_ff @(posedge clk) begin
      if (!rstN || clearAll) begin
         for (int i = 0; i < 5; i++) begin
            cntQ[i] <= '0;
         end
         firstRecQ <= '0;
      end else begin
         for (int i = 0; i < 5; i++) begin
            if (incVec[i] && cntQ[i] != '1) begin
               cntQ[i] <= cntQ[i] + 1'b1;
            end
         end
         // Record locks on the first event, checker ahead of tracker
         if (!firstRecQ.valid && (chkRec.valid || trkRec.valid)) begin
            firstRecQ <= chkRec.valid ? chkRec : trkRec;
         end
      end
   end

   // Read data captured in the setup phase, held through access
   always_ff @(posedge clk) begin
      if (!rstN) begin
         prdata <= '0;
      end else if (psel && !penable && !pwrite) begin
         prdata <= rdData;
      end
   end

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = psel & penable & ~addrHit;

   // APB master keeps psel up through the access phase
   apbEnable: assert property (@(posedge clk) disable iff (!rstN) penable |-> psel);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the sniffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module snifferTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/VsnifferTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi
exit 1

// ==== tb/snifferCheck.sv ====
// Reference model of the sniffer rules and APB read checker
// Expected counters, first-violation record and in-flight table
`timescale 1ns/1ps
`default_nettype none

module snifferCheck #(
   parameter int trackDepth = 8
) (
   input  logic            clk,
   input  logic            rstN,
   input  logic            softReset,
   input  ccipPkg::txChanT c0Tx,
   input  ccipPkg::txChanT c1Tx,
   input  ccipPkg::rxChanT c0Rx,
   input  ccipPkg::rxChanT c1Rx,
   input  logic [7:0]      paddr,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  logic [31:0]     pwdata,
   input  logic [31:0]     prdata,
   input  logic            pready,
   input  logic            pslverr,
   output int              errCount,
   output int              readCount
);
   import ccipPkg::*;
   import snifferPkg::*;

   // Expected counters in register order
   int          cnt [5];
   logic        recValid;
   logic [2:0]  recCode;
   logic [7:0]  recTag;
   // Write burst state of the model
   logic        inBurst;
   int          left;
   trackReqT    hold;
   trackReqT    tab [trackDepth];
   trackReqT    newTab [trackDepth];
   trackReqT    rdReq;
   trackReqT    wrReq;
   trackReqT    tr;
   logic [2:0]  chkCode;
   logic [7:0]  chkTag;
   logic [2:0]  trkCode;
   logic [7:0]  trkTag;
   logic        r0;
   logic        r1;
   logic        found0;
   logic        found1;
   logic        full;
   logic        ovl;
   int          freeIdx;
   logic [31:0] exp;
   logic        mapped;

   // Line ranges overlap when each starts before the other ends
   function automatic logic overlaps(trackReqT a, trackReqT b);
      int aEnd;
      int bEnd;
      aEnd = int'(a.lineAddr) + int'(a.clNum);
      bEnd = int'(b.lineAddr) + int'(b.clNum);
      return (int'(a.lineAddr) <= bEnd) && (int'(b.lineAddr) <= aEnd);
   endfunction

   always @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 5; i++) begin
            cnt[i] = 0;
         end
         recValid = 1'b0;
         recCode  = 3'd0;
         recTag   = 8'h0;
         inBurst  = 1'b0;
         left     = 0;
         hold     = '0;
         for (int i = 0; i < trackDepth; i++) begin
            tab[i] = '0;
         end
         errCount  = 0;
         readCount = 0;
      end else begin
         chkCode = 3'd0;
         chkTag  = 8'h0;
         trkCode = 3'd0;
         trkTag  = 8'h0;
         rdReq   = '0;
         wrReq   = '0;
         if (softReset) begin
            // Counted once per cycle and the rest of the beat ignored
            if (c0Tx.valid || c1Tx.valid || c0Rx.valid || c1Rx.valid) begin
               cnt[0]++;
               chkCode = 3'd1;
               chkTag  = c0Tx.valid ? c0Tx.hdr.mdata :
                         c1Tx.valid ? c1Tx.hdr.mdata :
                         c0Rx.valid ? c0Rx.hdr.mdata : c1Rx.hdr.mdata;
            end
         end else begin
            if (c0Tx.valid) begin
               if (c0Tx.hdr.clNum == cl3) begin
                  cnt[1]++;
                  chkCode = 3'd2;
                  chkTag  = c0Tx.hdr.mdata;
               end else begin
                  rdReq = '{1'b1, c0Tx.hdr.lineAddr, c0Tx.hdr.clNum, c0Tx.hdr.mdata};
               end
            end
            if (c1Tx.valid) begin
               if (inBurst ? c1Tx.hdr.sop : !c1Tx.hdr.sop) begin
                  cnt[2]++;
                  if (chkCode == 3'd0) begin
                     chkCode = 3'd3;
                     chkTag  = c1Tx.hdr.mdata;
                  end
               end
               // Any sop beat opens a new burst
               if (c1Tx.hdr.sop) begin
                  wrReq   = '{1'b1, c1Tx.hdr.lineAddr, c1Tx.hdr.clNum, c1Tx.hdr.mdata};
                  inBurst = (c1Tx.hdr.clNum != cl1);
                  left    = int'(c1Tx.hdr.clNum);
               end else if (inBurst) begin
                  left--;
                  if (left == 0) begin
                     inBurst = 1'b0;
                  end
               end
            end
         end

         // Read goes to the table ahead of a write from the same cycle
         if (rdReq.valid) begin
            tr = rdReq;
            if (wrReq.valid && !hold.valid) begin
               hold = wrReq;
            end
         end else if (hold.valid) begin
            tr   = hold;
            hold = wrReq;
         end else begin
            tr = wrReq;
         end

         // Table lookups use the state before this cycle
         r0      = c0Rx.valid && !softReset;
         r1      = c1Rx.valid && !softReset;
         found0  = 1'b0;
         found1  = 1'b0;
         full    = 1'b1;
         ovl     = 1'b0;
         freeIdx = -1;
         newTab  = tab;
         for (int i = trackDepth - 1; i >= 0; i--) begin
            if (!tab[i].valid) begin
               full    = 1'b0;
               freeIdx = i;
            end else begin
               if (r0 && tab[i].mdata == c0Rx.hdr.mdata) begin
                  found0          = 1'b1;
                  newTab[i].valid = 1'b0;
               end
               if (r1 && tab[i].mdata == c1Rx.hdr.mdata) begin
                  found1          = 1'b1;
                  newTab[i].valid = 1'b0;
               end
               if (overlaps(tab[i], tr)) begin
                  ovl = 1'b1;
               end
            end
         end
         if (tr.valid && !full) begin
            if (ovl) begin
               cnt[3]++;
               trkCode = 3'd4;
               trkTag  = tr.mdata;
            end
            newTab[freeIdx] = tr;
         end
         tab = newTab;
         // Orphans on both response channels count once per cycle
         if ((r0 && !found0) || (r1 && !found1)) begin
            cnt[4]++;
            if (trkCode == 3'd0) begin
               trkCode = 3'd5;
               trkTag  = (r0 && !found0) ? c0Rx.hdr.mdata : c1Rx.hdr.mdata;
            end
         end

         if (!recValid && (chkCode != 3'd0 || trkCode != 3'd0)) begin
            recValid = 1'b1;
            recCode  = (chkCode != 3'd0) ? chkCode : trkCode;
            recTag   = (chkCode != 3'd0) ? chkTag : trkTag;
         end

         if (psel && penable && pwrite && paddr == 8'h18 && pwdata[0]) begin
            for (int i = 0; i < 5; i++) begin
               cnt[i] = 0;
            end
            recValid = 1'b0;
            recCode  = 3'd0;
            recTag   = 8'h0;
         end

         // Completed APB read
         if (psel && penable && !pwrite) begin
            readCount++;
            mapped = 1'b1;
            case (paddr)
               8'h00:   exp = cnt[0];
               8'h04:   exp = cnt[1];
               8'h08:   exp = cnt[2];
               8'h0C:   exp = cnt[3];
               8'h10:   exp = cnt[4];
               8'h14:   exp = {20'h0, recValid, recCode, recTag};
               8'h18:   exp = 32'h0;
               default: begin
                  exp    = 32'h0;
                  mapped = 1'b0;
               end
            endcase
            if (!pready) begin
               errCount++;
               $display("pready was low during an APB access at time %0t", $time);
            end
            if (mapped && prdata !== exp) begin
               errCount++;
               $display("ERR %0t prdata[%02h] expected %08h got %08h", $time, paddr, exp, prdata);
            end
            if (pslverr !== !mapped) begin
               errCount++;
               $display("ERR %0t pslverr[%02h] expected %0b got %0b", $time, paddr, !mapped,
                        pslverr);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/snifferTb.sv ====
// Testbench top for the sniffer
// Clock, reset, seeded random channel phases and APB register reads
`timescale 1ns/1ps
`default_nettype none

module snifferTb;
   import ccipPkg::*;

   localparam int trackDepth = 8;

   logic        clk;
   logic        rstN;
   logic        softReset;
   txChanT      c0Tx;
   txChanT      c1Tx;
   rxChanT      c0Rx;
   rxChanT      c1Rx;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   int          errCount;
   int          readCount;
   int          timeouts;
   integer      seed;
   // Next fresh tag, and tags that may still get a response
   logic [7:0]  nextTag;
   logic [7:0]  issued [$];
   int          wrLeft;
   logic [7:0]  wrTag;

   ccipSnifferTop #(.trackDepth(trackDepth)) dut_i (.*);

   snifferCheck #(.trackDepth(trackDepth)) check_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic txChanT makeTx(logic v, logic [15:0] a, clNumE cl, logic s,
                                     logic [7:0] t);
      txChanT x;
      x.valid        = v;
      x.hdr.lineAddr = a;
      x.hdr.clNum    = cl;
      x.hdr.sop      = s;
      x.hdr.mdata    = t;
      return x;
   endfunction

   function automatic rxChanT makeRx(logic v, respTypeE rt, logic [7:0] t);
      rxChanT x;
      x.valid        = v;
      x.hdr.respType = rt;
      x.hdr.mdata    = t;
      return x;
   endfunction

   task automatic driveBeat(txChanT a, txChanT b, rxChanT x, rxChanT y, logic sr);
      @(posedge clk);
      c0Tx      <= a;
      c1Tx      <= b;
      c0Rx      <= x;
      c1Rx      <= y;
      softReset <= sr;
   endtask

   task automatic newTag(output logic [7:0] t);
      t = nextTag;
      issued.push_back(nextTag);
      nextTag++;
   endtask

   // Response to a pending tag, or to an unknown one now and then
   task automatic pickResp(logic en, respTypeE rt, output rxChanT x);
      logic [31:0] r;
      int          idx;
      r = $random(seed);
      if (!en) begin
         x = makeRx(1'b0, rt, 8'h0);
      end else if (issued.size() > 0 && r[1:0] != 2'd0) begin
         idx = int'(r[15:8]) % issued.size();
         x   = makeRx(1'b1, rt, issued[idx]);
         issued.delete(idx);
      end else begin
         x = makeRx(1'b1, rt, {4'hF, r[7:4]});
      end
   endtask

   task automatic readBeat(logic en, logic [31:0] r, output txChanT x);
      logic [7:0] t;
      x = makeTx(1'b0, 16'h0, cl1, 1'b0, 8'h0);
      if (en) begin
         newTag(t);
         x = makeTx(1'b1, {11'h0, r[8:4]}, clNumE'(r[10:9]), 1'b0, t);
      end
   endtask

   // Mostly legal bursts, sop wrong on about one beat in eight
   task automatic writeBeat(logic en, logic [31:0] r, output txChanT x);
      logic s;
      x = makeTx(1'b0, 16'h0, cl1, 1'b0, 8'h0);
      if (en) begin
         s = (wrLeft == 0) ? (r[23:21] != 3'd0) : (r[23:21] == 3'd0);
         if (s) begin
            newTag(wrTag);
            wrLeft = int'(r[25:24]);
         end else if (wrLeft > 0) begin
            wrLeft--;
         end
         x = makeTx(1'b1, {11'h0, r[20:16]}, clNumE'(r[25:24]), s, wrTag);
      end
   endtask

   task automatic apbAccess(logic wr, logic [7:0] a, logic [31:0] d);
      int waitCnt;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= a;
      pwdata  <= d;
      @(posedge clk);
      penable <= 1'b1;
      waitCnt = 0;
      do begin
         @(posedge clk);
         waitCnt++;
      end while (!pready && waitCnt < 16);
      if (!pready) begin
         timeouts++;
         $display("APB access to offset %02h never saw pready", a);
      end
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // Quiet gap so the counters settle, then read every register
   task automatic endPhase();
      txChanT noTx;
      rxChanT noRx;
      noTx = makeTx(1'b0, 16'h0, cl1, 1'b0, 8'h0);
      noRx = makeRx(1'b0, rdResp, 8'h0);
      repeat (4) driveBeat(noTx, noTx, noRx, noRx, 1'b0);
      for (int a = 0; a <= 8'h18; a += 4) begin
         apbAccess(1'b0, 8'(a), 32'h0);
      end
   endtask

   initial begin : stimulus
      logic [31:0] r;
      txChanT      rd;
      txChanT      wr;
      txChanT      noTx;
      rxChanT      x;
      rxChanT      y;
      rxChanT      noRx;
      seed      = 32'h3755;
      timeouts  = 0;
      nextTag   = 8'h10;
      wrLeft    = 0;
      wrTag     = 8'h0;
      noTx      = makeTx(1'b0, 16'h0, cl1, 1'b0, 8'h0);
      noRx      = makeRx(1'b0, rdResp, 8'h0);
      rstN      = 1'b0;
      softReset = 1'b0;
      c0Tx      = noTx;
      c1Tx      = noTx;
      c0Rx      = noRx;
      c1Rx      = noRx;
      paddr     = 8'h0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = 32'h0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;

      // Traffic on all channels during soft reset
      for (int i = 0; i < 6; i++) begin
         r = $random(seed);
         driveBeat(makeTx(r[0], {11'h0, r[8:4]}, cl2, 1'b1, {5'h1C, r[11:9]}),
                   makeTx(r[1], {11'h0, r[16:12]}, cl1, 1'b1, 8'hE8),
                   makeRx(r[2], rdResp, 8'hE0), makeRx(r[3], wrResp, 8'hE1), 1'b1);
      end
      endPhase();
      // Tag seen only during soft reset is an orphan now
      driveBeat(noTx, noTx, makeRx(1'b1, rdResp, 8'hE0), noRx, 1'b0);

      // Reads of every length
      for (int i = 0; i < 24; i++) begin
         r = $random(seed);
         readBeat(r[0], r, rd);
         pickResp(r[12] & r[13], rdResp, x);
         driveBeat(rd, noTx, x, noRx, 1'b0);
      end
      endPhase();

      // Write bursts with sop errors
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         writeBeat(r[0], r, wr);
         pickResp(r[12] & r[13], wrResp, y);
         driveBeat(noTx, wr, noRx, y, 1'b0);
      end
      endPhase();

      // Mixed traffic that overfills the table, responses on both channels
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         readBeat(r[2] | r[3], r, rd);
         writeBeat(r[0], r, wr);
         pickResp(r[26] & r[27], rdResp, x);
         pickResp(r[28] & r[29], wrResp, y);
         driveBeat(rd, wr, x, y, 1'b0);
      end
      endPhase();

      // Clear everything, read back, then an unmapped offset
      apbAccess(1'b1, 8'h18, 32'h1);
      endPhase();
      apbAccess(1'b0, 8'h40, 32'h0);
      repeat (2) @(posedge clk);

      $display("Reads checked %0d, errors %0d, timeouts %0d", readCount, errCount, timeouts);
      if (errCount == 0 && timeouts == 0 && readCount > 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
